// File: filelist.f
source/ppuPkg.sv
source/lcdRegisters.sv
source/lcdTiming.sv
source/bgFetcher.sv
source/lineOutput.sv
source/ppuTop.sv
bench/ppuTop_assert.sv
bench/ppuTb.sv

// File: run.sh
#!/bin/sh
# Builds the bench with Verilator and runs it; a $fatal gives a failing status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module ppuTb -f filelist.f -o ppuSim
./obj_dir/ppuSim

// File: bench/ppuTb.sv
module ppuTb;
   timeunit 1ns;
   timeprecision 100ps;

   import ppuPkg::*;

   localparam int ackLimit   = 20;
   localparam int frameLimit = 80000; // A frame is 70224 cycles.

   logic     clock, rstN, cyc, stb, we, ack, vramRead, irq, pixelValid;
   busAddrT  adr;
   regByteT  datWrite, datRead, vramData, pixelLine;
   vramAddrT vramAddr, readAddr;
   pixelXT   pixelX;
   shadeT    pixel;
   logic     readHit;

   regByteT vram [0:8191];
   integer  seed;
   regByteT paletteRef;
   regByteT lycRef;
   regByteT expectLine = 8'd0;
   pixelXT  expectX    = 8'd0;
   int      linesDone  = 0;
   logic    quiet      = 1'b0; // Set while the LCD is off.

   ppuTop i_ppuTop (
      .clock(clock), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datWrite(datWrite), .ack(ack), .datRead(datRead), .vramAddr(vramAddr),
      .vramRead(vramRead), .vramData(vramData), .irq(irq), .pixelValid(pixelValid),
      .pixelX(pixelX), .pixelLine(pixelLine), .pixel(pixel)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // VRAM model with one-cycle read latency.
   initial begin
      vramData = 8'h00;
      forever begin
         @(negedge clock);
         readHit  = vramRead;
         readAddr = vramAddr;
         @(posedge clock);
         #1;
         if (readHit) vramData = vram[readAddr];
      end
   end

   function automatic shadeT refShade(regByteT line, pixelXT x, regByteT palette);
      vramAddrT mapAddr;
      vramAddrT rowAddr;
      int       bitPos;
      int       colour;
      mapAddr = vramAddrT'(6144 + (line / 8) * 32 + x / 8); // Map at 0x1800.
      rowAddr = vramAddrT'(vram[mapAddr] * 16 + (line % 8) * 2);
      bitPos  = 7 - x % 8;
      colour  = {vram[rowAddr + 13'd1][bitPos], vram[rowAddr][bitPos]};
      return palette[colour * 2 +: 2];
   endfunction

   task automatic failRun(string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkByte(regByteT got, regByteT want, string name);
      if (got !== want)
         failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic checkX(pixelXT got, pixelXT want, string name);
      if (got !== want)
         failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic checkShade(shadeT got, shadeT want, string name);
      if (got !== want)
         failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic busCycle(logic write, busAddrT addr, regByteT wdata,
                           output regByteT rdata, output logic irqSeen);
      int n;
      cyc      = 1'b1;
      stb      = 1'b1;
      we       = write;
      adr      = addr;
      datWrite = wdata;
      for (n = 0; n < ackLimit; n++) begin
         @(negedge clock);
         if (ack) break;
      end
      if (n == ackLimit) failRun($sformatf("no Wishbone ack at address 0x%h", addr));
      rdata   = datRead;
      irqSeen = irq;
      @(posedge clock);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic writeReg(busAddrT addr, regByteT data);
      regByteT rdata;
      logic    irqSeen;
      busCycle(1'b1, addr, data, rdata, irqSeen);
   endtask

   task automatic readCheck(busAddrT addr, regByteT want, string name);
      regByteT rdata;
      logic    irqSeen;
      busCycle(1'b0, addr, 8'h00, rdata, irqSeen);
      checkByte(rdata, want, name);
   endtask

   task automatic stepLy(inout regByteT lastLy, input regByteT lyNow, inout bit wrapped);
      if (lyNow != lastLy) begin
         checkByte(lyNow, (lastLy == 8'd153) ? 8'd0 : lastLy + 8'd1, "LY");
         if (lyNow == 8'd0) wrapped = 1'b1;
         lastLy = lyNow;
      end
   endtask

   // STAT is trusted only when LY reads the same before and after it.
   task automatic pollFrame();
      regByteT lyA, lyB, stat;
      regByteT lastLy = 8'd0;
      regByteT curLy  = 8'd0;
      logic    irqSeen, unused;
      int      phase  = 0;
      int      seen   = 0;
      int      ph;
      bit      wrapped = 1'b0;
      for (int polls = 0; polls < 20000 && !wrapped; polls++) begin
         busCycle(1'b0, lyAddr, 8'h00, lyA, unused);
         stepLy(lastLy, lyA, wrapped);
         busCycle(1'b0, statAddr, 8'h00, stat, irqSeen);
         busCycle(1'b0, lyAddr, 8'h00, lyB, unused);
         stepLy(lastLy, lyB, wrapped);
         if (lyA == lyB) begin
            checkByte({7'd0, stat[2]}, {7'd0, lyA == lycRef}, "STAT coincidence");
            checkByte({7'd0, irqSeen}, {7'd0, stat[1:0] == vBlank}, "irq");
            if (lyA != curLy) begin
               if (curLy < 8'd144 && seen != 7)
                  failRun($sformatf("line %0d skipped a mode", curLy));
               curLy = lyA;
               phase = 0;
               seen  = 0;
            end
            if (lyA >= 8'd144) begin
               checkByte({6'd0, stat[1:0]}, {6'd0, vBlank}, "STAT mode");
            end else begin
               case (stat[1:0])
                  oamScan: ph = 0;
                  drawing: ph = 1;
                  hBlank:  ph = 2;
                  default: failRun($sformatf("vBlank shown on visible line %0d", lyA));
               endcase
               if (ph < phase) failRun($sformatf("mode order broken on line %0d", lyA));
               phase = ph;
               seen  = seen | (1 << ph);
            end
         end
      end
      if (!wrapped) failRun("LY did not wrap to 0 within the poll limit");
   endtask

   task automatic waitIrq();
      int n;
      for (n = 0; n < frameLimit; n++) begin
         @(negedge clock);
         if (irq) break;
      end
      if (n == frameLimit) failRun("timed out waiting for vertical blank");
      @(posedge clock);
      #1;
   endtask

   // Compare process for the pixel stream.
   always @(negedge clock) begin
      if (quiet && (pixelValid || irq)) failRun("activity while the LCD is disabled");
      if (pixelValid) begin
         checkX(pixelX, expectX, "pixelX");
         checkByte(pixelLine, expectLine, "pixelLine");
         checkShade(pixel, refShade(expectLine, expectX, paletteRef), "pixel");
         if (expectX == 8'd159) begin
            expectX    = 8'd0;
            expectLine = (expectLine == 8'd143) ? 8'd0 : expectLine + 8'd1;
            linesDone  = linesDone + 1;
         end else begin
            expectX = expectX + 8'd1;
         end
      end else if (expectX != 8'd0) begin
         failRun("pixel stream stopped before column 159");
      end
   end

   initial begin
      int n;
      int target;
      seed     = 93;
      rstN     = 1'b0;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = 16'h0000;
      datWrite = 8'h00;
      for (int a = 0; a < 8192; a++) vram[a] = regByteT'($random(seed));
      repeat (5) @(posedge clock);
      #1;
      rstN = 1'b1;
      @(negedge clock);
      if (ack || irq || vramRead || pixelValid) failRun("outputs not idle after reset");
      @(posedge clock);
      #1;

      writeReg(lycAddr, 8'h5A);
      readCheck(lycAddr, 8'h5A, "LYC");
      writeReg(bgpAddr, 8'hE4);
      readCheck(bgpAddr, 8'hE4, "BGP");
      writeReg(lcdcAddr, 8'h11);
      readCheck(lcdcAddr, 8'h11, "LCDC");
      writeReg(statAddr, 8'hFF);
      readCheck(statAddr, 8'hF8, "STAT"); // Low three bits are status.
      writeReg(lyAddr, 8'h33);
      readCheck(lyAddr, 8'h00, "LY");
      writeReg(16'hFF42, 8'h12);
      readCheck(16'hFF42, 8'hFF, "unmapped read");

      lycRef     = 8'd5;
      paletteRef = 8'hE4;
      writeReg(lycAddr, lycRef);
      writeReg(lcdcAddr, 8'h91);
      pollFrame();
      waitIrq();
      if (linesDone != 288) failRun($sformatf("saw %0d lines, not 288", linesDone));

      paletteRef = 8'h1B;
      writeReg(bgpAddr, paletteRef);
      target = linesDone + 144;
      for (n = 0; n < frameLimit && linesDone < target; n++) @(negedge clock);
      if (linesDone < target) failRun("timed out waiting for a frame of pixels");
      @(posedge clock);
      #1;

      waitIrq();
      writeReg(lcdcAddr, 8'h11);
      quiet = 1'b1;
      readCheck(lyAddr, 8'h00, "LY");
      readCheck(statAddr, 8'hF8, "STAT");
      repeat (2000) @(negedge clock);

      $display("** PASS **");
      $finish;
   end

endmodule

// File: bench/ppuTop_assert.sv
module ppuTopAssert (
   input logic            clock,
   input logic            rstN,
   input logic            stb,
   input logic            ack,
   input logic            vramRead,
   input logic            pixelValid,
   input ppuPkg::lcdModeT mode
);
   timeunit 1ns;
   timeprecision 100ps;

   import ppuPkg::*;

   ackWithStb: assert property (@(posedge clock) disable iff (!rstN) ack |-> stb)
      else $error("ack high without stb");

   readInDrawing: assert property (@(posedge clock) disable iff (!rstN)
      vramRead |-> mode == drawing)
      else $error("VRAM read outside drawing mode");

   pixelsInHBlank: assert property (@(posedge clock) disable iff (!rstN)
      pixelValid |-> mode == hBlank)
      else $error("pixel stream outside hBlank");

endmodule

bind ppuTop ppuTopAssert i_ppuTopAssert (
   .clock(clock), .rstN(rstN), .stb(stb), .ack(ack), .vramRead(vramRead),
   .pixelValid(pixelValid), .mode(mode)
);

// File: source/ppuTop.sv
module ppuTop #(
   parameter int lineCycles   = 456,
   parameter int oamCycles    = 80,
   parameter int drawEnd      = 252,
   parameter int visibleLines = 144,
   parameter int totalLines   = 154
) (
   input  logic              clock,
   input  logic              rstN,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  ppuPkg::busAddrT   adr,
   input  ppuPkg::regByteT   datWrite,
   output logic              ack,
   output ppuPkg::regByteT   datRead,
   output ppuPkg::vramAddrT  vramAddr,
   output logic              vramRead,
   input  ppuPkg::regByteT   vramData,
   output logic              irq,
   output logic              pixelValid,
   output ppuPkg::pixelXT    pixelX,
   output ppuPkg::regByteT   pixelLine,
   output ppuPkg::shadeT     pixel
);

   import ppuPkg::*;

   logic       lcdEnable;
   regByteT    lyc;
   regByteT    bgp;
   lcdModeT    mode;
   regByteT    ly;
   logic       lineStart;
   logic       coincidence;
   logic       tileWrite;
   logic [4:0] tileSlot;
   regByteT    tileLow;
   regByteT    tileHigh;

   lcdRegisters i_lcdRegisters (
      .clock(clock), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datWrite(datWrite), .ack(ack), .datRead(datRead), .mode(mode), .ly(ly),
      .coincidence(coincidence), .lcdEnable(lcdEnable), .lyc(lyc), .bgp(bgp)
   );

   lcdTiming #(
      .lineCycles(lineCycles), .oamCycles(oamCycles), .drawEnd(drawEnd),
      .visibleLines(visibleLines), .totalLines(totalLines)
   ) i_lcdTiming (
      .clock(clock), .rstN(rstN), .lcdEnable(lcdEnable), .lyc(lyc), .mode(mode),
      .ly(ly), .lineStart(lineStart), .coincidence(coincidence), .irq(irq)
   );

   bgFetcher i_bgFetcher (
      .clock(clock), .rstN(rstN), .lineStart(lineStart), .ly(ly),
      .vramAddr(vramAddr), .vramRead(vramRead), .vramData(vramData),
      .tileWrite(tileWrite), .tileSlot(tileSlot), .tileLow(tileLow),
      .tileHigh(tileHigh)
   );

   lineOutput #(
      .visibleLines(visibleLines)
   ) i_lineOutput (
      .clock(clock), .rstN(rstN), .mode(mode), .ly(ly), .bgp(bgp),
      .tileWrite(tileWrite), .tileSlot(tileSlot), .tileLow(tileLow),
      .tileHigh(tileHigh), .pixelValid(pixelValid), .pixelX(pixelX),
      .pixelLine(pixelLine), .pixel(pixel)
   );

endmodule

// File: source/lineOutput.sv
module lineOutput #(
   parameter int visibleLines = 144
) (
   input  logic             clock,
   input  logic             rstN,
   input  ppuPkg::lcdModeT  mode,
   input  ppuPkg::regByteT  ly,
   input  ppuPkg::regByteT  bgp,
   input  logic             tileWrite,
   input  logic [4:0]       tileSlot,
   input  ppuPkg::regByteT  tileLow,
   input  ppuPkg::regByteT  tileHigh,
   output logic             pixelValid,
   output ppuPkg::pixelXT   pixelX,
   output ppuPkg::regByteT  pixelLine,
   output ppuPkg::shadeT    pixel
);

   import ppuPkg::*;

   localparam regByteT visibleLy = regByteT'(visibleLines);
   localparam pixelXT  lastX     = screenWidth - 8'd1;

   shadeT   indexBuf [screenWidth];
   lcdModeT prevMode;
   logic    hBlankEntry;

   function automatic shadeT mapShade(regByteT palette, shadeT index);
      return shadeT'(palette >> {index, 1'b0});
   endfunction

   assign hBlankEntry = (mode == hBlank) && (prevMode == drawing) && (ly < visibleLy);

   always_ff @(posedge clock) begin
      if (tileWrite) begin
         for (int i = 0; i < 8; i++) begin
            indexBuf[{tileSlot, 3'(i)}] <= {tileHigh[7 - i], tileLow[7 - i]}; // MSB leftmost.
         end
      end
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         prevMode   <= hBlank;
         pixelValid <= 1'b0;
         pixelX     <= '0;
      end else begin
         prevMode <= mode;
         if (hBlankEntry) begin
            pixelValid <= 1'b1;
            pixelX     <= '0;
         end else if (pixelValid) begin
            if (pixelX == lastX) pixelValid <= 1'b0;
            else                 pixelX     <= pixelX + 8'd1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (hBlankEntry) begin
         pixelLine <= ly;
         pixel     <= mapShade(bgp, indexBuf[0]);
      end else if (pixelValid && pixelX != lastX) begin
         pixel <= mapShade(bgp, indexBuf[pixelX + 8'd1]);
      end
   end

endmodule

// File: source/bgFetcher.sv
module bgFetcher (
   input  logic              clock,
   input  logic              rstN,
   input  logic              lineStart,
   input  ppuPkg::regByteT   ly,
   output ppuPkg::vramAddrT  vramAddr,
   output logic              vramRead,
   input  ppuPkg::regByteT   vramData,
   output logic              tileWrite,
   output logic [4:0]        tileSlot,
   output ppuPkg::regByteT   tileLow,
   output ppuPkg::regByteT   tileHigh
);

   import ppuPkg::*;

   localparam logic [4:0] lastSlot = tilesPerLine - 5'd1;

   // Step 0 reads the map, step 2 the low plane and step 4 the high plane.
   // Odd steps take the data.
   logic       busy;
   logic [2:0] step;
   logic [4:0] slot;
   regByteT    tileNumber;
   vramAddrT   mapAddr;
   vramAddrT   dataAddr;

   assign mapAddr = tileMapBase + vramAddrT'(ly[7:3]) * bytesPerMapRow
                    + vramAddrT'(slot);

   // Step 4 has bit 2 set and so picks the high plane.
   assign dataAddr = vramAddrT'(tileNumber) * bytesPerTile
                     + vramAddrT'({ly[2:0], step[2]});

   assign vramRead = busy && !step[0]; // Even steps issue reads.
   assign vramAddr = (step == 3'd0) ? mapAddr : dataAddr;

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         busy      <= 1'b0;
         step      <= '0;
         slot      <= '0;
         tileWrite <= 1'b0;
      end else begin
         tileWrite <= busy && (step == 3'd5);
         if (lineStart) begin
            busy <= 1'b1;
            step <= '0;
            slot <= '0;
         end else if (busy) begin
            if (step == 3'd5) begin
               step <= '0;
               slot <= slot + 5'd1;
               if (slot == lastSlot) begin
                  busy <= 1'b0; // Line complete.
               end
            end else begin
               step <= step + 3'd1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (busy) begin
         case (step)
            3'd1: tileNumber <= vramData;
            3'd3: tileLow    <= vramData;
            3'd5: begin
               tileHigh <= vramData;
               tileSlot <= slot;
            end
            default: ;
         endcase
      end
   end

endmodule

// File: source/lcdTiming.sv
module lcdTiming #(
   parameter int lineCycles   = 456,
   parameter int oamCycles    = 80,
   parameter int drawEnd      = 252,
   parameter int visibleLines = 144,
   parameter int totalLines   = 154
) (
   input  logic             clock,
   input  logic             rstN,
   input  logic             lcdEnable,
   input  ppuPkg::regByteT  lyc,
   output ppuPkg::lcdModeT  mode,
   output ppuPkg::regByteT  ly,
   output logic             lineStart,
   output logic             coincidence,
   output logic             irq
);

   import ppuPkg::*;

   localparam int cycleBits = $clog2(lineCycles);

   localparam logic [cycleBits-1:0] lastCycle = cycleBits'(lineCycles - 1);
   localparam logic [cycleBits-1:0] oamEnd    = cycleBits'(oamCycles);
   localparam logic [cycleBits-1:0] drawStop  = cycleBits'(drawEnd);
   localparam regByteT visibleLy = regByteT'(visibleLines);
   localparam regByteT lastLine  = regByteT'(totalLines - 1);

   logic [cycleBits-1:0] cycleCount;

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         cycleCount <= '0;
         ly         <= '0;
      end else if (!lcdEnable) begin
         cycleCount <= '0; // Held while display is off.
         ly         <= '0;
      end else if (cycleCount == lastCycle) begin
         cycleCount <= '0;
         ly         <= (ly == lastLine) ? '0 : ly + 8'd1;
      end else begin
         cycleCount <= cycleCount + 1'b1;
      end
   end

   always_comb begin
      if (!lcdEnable)                mode = hBlank;
      else if (ly >= visibleLy)      mode = vBlank; // Whole line.
      else if (cycleCount < oamEnd)  mode = oamScan;
      else if (cycleCount < drawStop) mode = drawing;
      else                           mode = hBlank;
   end

   assign lineStart   = lcdEnable && (ly < visibleLy) && (cycleCount == oamEnd);
   assign coincidence = (ly == lyc);
   assign irq         = (mode == vBlank);

endmodule

// File: source/lcdRegisters.sv
module lcdRegisters (
   input  logic             clock,
   input  logic             rstN,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  ppuPkg::busAddrT  adr,
   input  ppuPkg::regByteT  datWrite,
   output logic             ack,
   output ppuPkg::regByteT  datRead,
   input  ppuPkg::lcdModeT  mode,
   input  ppuPkg::regByteT  ly,
   input  logic             coincidence,
   output logic             lcdEnable,
   output ppuPkg::regByteT  lyc,
   output ppuPkg::regByteT  bgp
);

   import ppuPkg::*;

   regByteT    lcdc;
   logic [4:0] statHigh;
   logic       request;
   regByteT    readValue;

   assign request   = cyc && stb && !ack; // New cycle not yet acked.
   assign lcdEnable = lcdc[7];

   always_comb begin
      case (adr)
         lcdcAddr: readValue = lcdc;
         statAddr: readValue = {statHigh, coincidence, mode};
         lyAddr:   readValue = ly;
         lycAddr:  readValue = lyc;
         bgpAddr:  readValue = bgp;
         default:  readValue = 8'hFF; // Open bus.
      endcase
   end

   always_ff @(posedge clock or negedge rstN) begin
      if (!rstN) begin
         ack      <= 1'b0;
         lcdc     <= '0;
         statHigh <= '0;
         lyc      <= '0;
         bgp      <= '0;
      end else begin
         ack <= request;
         if (request && we) begin
            case (adr)
               lcdcAddr: lcdc     <= datWrite;
               statAddr: statHigh <= datWrite[7:3]; // Low bits are status.
               lycAddr:  lyc      <= datWrite;
               bgpAddr:  bgp      <= datWrite;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clock) begin
      if (request) begin
         datRead <= readValue; // Valid with ack.
      end
   end

endmodule

// File: source/ppuPkg.sv
package ppuPkg;

   typedef enum logic [1:0] {
      hBlank  = 2'd0,
      vBlank  = 2'd1,
      oamScan = 2'd2,
      drawing = 2'd3
   } lcdModeT;

   typedef logic [1:0]  shadeT;
   typedef logic [7:0]  regByteT;
   typedef logic [15:0] busAddrT;
   typedef logic [12:0] vramAddrT;
   typedef logic [7:0]  pixelXT;

   // CPU-visible register map.
   localparam busAddrT lcdcAddr = 16'hFF40;
   localparam busAddrT statAddr = 16'hFF41;
   localparam busAddrT lyAddr   = 16'hFF44;
   localparam busAddrT lycAddr  = 16'hFF45;
   localparam busAddrT bgpAddr  = 16'hFF47;

   localparam vramAddrT tileMapBase = 13'h1800; // Fixed background map.

   localparam logic [4:0] tilesPerLine = 5'd20;
   localparam pixelXT     screenWidth  = 8'd160;

   localparam vramAddrT bytesPerTile   = 13'd16;
   localparam vramAddrT bytesPerMapRow = 13'd32;

endpackage
